// File: arch_map_table/arch_map_table.sv
`timescale 1ns/10ps
`include "retire_config.svh"

module arch_map_table (
	input  logic                                      clock,
	input  logic                                      reset,
	retire_if.sink                                    upd,
	output retire_pkg::phys_tag_t [`NUM_ARCH_REG-1:0] arch_map
);

	localparam int ENTRIES = `NUM_ARCH_REG;
	localparam int WAYS    = `RETIRE_WIDTH;

	logic [ENTRIES-1:0][WAYS-1:0]        hits;
	retire_pkg::phys_tag_t [ENTRIES-1:0] arch_map_next;

	tag_cam #(
		.ENTRIES  (ENTRIES),
		.SEARCHES (WAYS)
	) map_cam_i (
		.enable      (upd.update_en),
		.search_tags (upd.match_tag),
		.table_tags  (arch_map),
		.hits        (hits)
	);

	always_comb begin
		arch_map_next = arch_map;
		for (int i = 0; i < ENTRIES; i++) begin
			for (int j = 0; j < WAYS; j++) begin
				if (hits[i][j]) begin
					arch_map_next[i] = upd.write_tag[j];  // Highest way wins
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ENTRIES; i++) begin
				arch_map[i] <= retire_pkg::phys_tag_t'(i);  // Identity map
			end
		end else begin
			arch_map <= arch_map_next;
		end
	end

endmodule

// File: common/retire_config.svh
`ifndef RETIRE_CONFIG_SVH
`define RETIRE_CONFIG_SVH

// Retire group size of 1 or more ways
`define RETIRE_WIDTH 3

// Architectural register file size
`define NUM_ARCH_REG 32

// Physical register file size
// Must exceed NUM_ARCH_REG so the free queue starts non-empty
`define NUM_PHYS_REG 64

`endif

// File: common/retire_if.sv
`timescale 1ns/10ps
`include "retire_config.svh"

interface retire_if;

	// Map table update, one entry per way after chain merging
	logic [`RETIRE_WIDTH-1:0]                    update_en;
	retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0]   match_tag;  // Tag to look up in the map
	retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0]   write_tag;  // Last T_new of the chain

	// Freed physical registers, unmerged
	logic [`RETIRE_WIDTH-1:0]                    freed_valid;
	retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0]   freed_tag;

	modport stage (
		output update_en, match_tag, write_tag, freed_valid, freed_tag
	);

	modport sink (
		input update_en, match_tag, write_tag, freed_valid, freed_tag
	);

endinterface

// File: common/retire_pkg.sv
package retire_pkg;

	`include "retire_config.svh"

	// Physical register number
	typedef logic [$clog2(`NUM_PHYS_REG)-1:0] phys_tag_t;

	// Architectural register number
	typedef logic [$clog2(`NUM_ARCH_REG)-1:0] arch_idx_t;

	// One retiring instruction as delivered by the ROB
	typedef struct packed {
		logic      valid;
		phys_tag_t t_new;  // Tag written by this instruction
		phys_tag_t t_old;  // Tag it displaced, freed on retire
	} retire_way_t;

	// Tags not held by the architectural map after reset
	localparam int FREE_DEPTH = `NUM_PHYS_REG - `NUM_ARCH_REG;

endpackage

// File: project.f
+incdir+common
common/retire_pkg.sv
common/retire_if.sv
source/retire_merge.sv
source/tag_cam.sv
arch_map_table/arch_map_table.sv
source/freed_reg_queue.sv
source/retire_unit.sv
verification/retire_unit_chk.sv
verification/retire_unit_tb.sv

// File: source/freed_reg_queue.sv
`timescale 1ns/10ps
`include "retire_config.svh"

module freed_reg_queue (
	input  logic                  clock,
	input  logic                  reset,
	retire_if.sink                push,
	input  logic                  alloc_take,
	output logic                  alloc_valid,
	output retire_pkg::phys_tag_t alloc_tag
);

	localparam int DEPTH = retire_pkg::FREE_DEPTH;
	localparam int WAYS  = `RETIRE_WIDTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int NUM_W = $clog2(WAYS + 1);

	retire_pkg::phys_tag_t [DEPTH-1:0] mem;
	logic [PTR_W-1:0]                  head;
	logic [PTR_W-1:0]                  tail;
	logic [CNT_W-1:0]                  count;
	logic                              pop;
	logic [NUM_W-1:0]                  push_num;   // Valid freed tags this cycle
	logic [WAYS-1:0][PTR_W-1:0]        push_slot;  // Compacted write slot per way
	logic [PTR_W-1:0]                  head_next;
	logic [PTR_W-1:0]                  tail_next;

	assign alloc_valid = (count != '0);
	assign alloc_tag   = mem[head];
	assign pop         = alloc_take && alloc_valid;  // Take on empty is ignored

	// Valid ways fill consecutive slots from the tail, lowest way first
	always_comb begin
		push_num = '0;
		for (int w = 0; w < WAYS; w++) begin
			push_slot[w] = PTR_W'((int'(tail) + int'(push_num)) % DEPTH);
			if (push.freed_valid[w]) begin
				push_num = push_num + NUM_W'(1);
			end
		end
		tail_next = PTR_W'((int'(tail) + int'(push_num)) % DEPTH);
		head_next = PTR_W'((int'(head) + 1) % DEPTH);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// Tags above the arch range start out free
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= retire_pkg::phys_tag_t'(`NUM_ARCH_REG + i);
			end
			head  <= '0;
			tail  <= '0;  // Full, so tail wraps onto head
			count <= CNT_W'(DEPTH);
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				if (push.freed_valid[w]) begin
					mem[push_slot[w]] <= push.freed_tag[w];
				end
			end
			if (pop) begin
				head <= head_next;
			end
			tail  <= tail_next;
			count <= count + CNT_W'(push_num) - CNT_W'(pop);
		end
	end

endmodule

// File: source/retire_merge.sv
`timescale 1ns/10ps
`include "retire_config.svh"

module retire_merge (
	input  logic                                      clock,
	input  logic                                      reset,
	input  logic [`RETIRE_WIDTH-1:0]                  retire_valid,
	input  retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0] retire_t_new,
	input  retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0] retire_t_old,
	retire_if.stage                                   out
);

	localparam int WAYS = `RETIRE_WIDTH;

	retire_pkg::retire_way_t [WAYS-1:0] group;
	logic [WAYS-1:0]                    absorbed;   // Way continues an earlier way's chain
	retire_pkg::phys_tag_t [WAYS-1:0]   chain_tag;  // Final T_new reached from each way

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			group[w].valid = retire_valid[w];
			group[w].t_new = retire_t_new[w];
			group[w].t_old = retire_t_old[w];
		end
	end

	// A later way whose T_old is an earlier way's T_new renames the same
	// arch register again. The earlier way keeps the lookup, since its T_old
	// is the tag still sitting in the map, and takes the later T_new.
	always_comb begin
		for (int j = 0; j < WAYS; j++) begin
			absorbed[j] = 1'b0;
			for (int k = 0; k < j; k++) begin
				if (group[k].valid && (group[k].t_new == group[j].t_old)) begin
					absorbed[j] = 1'b1;
				end
			end
		end
	end

	// Follow the chain forward in way order
	always_comb begin
		for (int j = 0; j < WAYS; j++) begin
			chain_tag[j] = group[j].t_new;
			for (int k = j + 1; k < WAYS; k++) begin
				if (group[k].valid && (group[k].t_old == chain_tag[j])) begin
					chain_tag[j] = group[k].t_new;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out.update_en   <= '0;
			out.freed_valid <= '0;
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				out.update_en[w]   <= group[w].valid & ~absorbed[w];
				out.freed_valid[w] <= group[w].valid;  // Every retired T_old is freed
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int w = 0; w < WAYS; w++) begin
			out.match_tag[w] <= group[w].t_old;
			out.write_tag[w] <= chain_tag[w];
			out.freed_tag[w] <= group[w].t_old;
		end
	end

endmodule

// File: source/retire_unit.sv
`timescale 1ns/10ps
`include "retire_config.svh"

module retire_unit (
	input  logic                                      clock,
	input  logic                                      reset,
	input  logic [`RETIRE_WIDTH-1:0]                  retire_valid,
	input  retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0] retire_t_new,
	input  retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0] retire_t_old,
	input  logic                                      alloc_take,
	output logic                                      alloc_valid,
	output retire_pkg::phys_tag_t                     alloc_tag,
	output retire_pkg::phys_tag_t [`NUM_ARCH_REG-1:0] arch_map
);

	// Merged group between the two pipeline stages
	retire_if merged_if ();

	retire_merge retire_merge_i (
		.clock        (clock),
		.reset        (reset),
		.retire_valid (retire_valid),
		.retire_t_new (retire_t_new),
		.retire_t_old (retire_t_old),
		.out          (merged_if.stage)
	);

	arch_map_table arch_map_table_i (
		.clock    (clock),
		.reset    (reset),
		.upd      (merged_if.sink),
		.arch_map (arch_map)
	);

	freed_reg_queue freed_reg_queue_i (
		.clock       (clock),
		.reset       (reset),
		.push        (merged_if.sink),
		.alloc_take  (alloc_take),
		.alloc_valid (alloc_valid),
		.alloc_tag   (alloc_tag)
	);

endmodule

// File: source/tag_cam.sv
`timescale 1ns/10ps
`include "retire_config.svh"

module tag_cam #(
	parameter int ENTRIES  = `NUM_ARCH_REG,
	parameter int SEARCHES = `RETIRE_WIDTH
) (
	input  logic [SEARCHES-1:0]                  enable,
	input  retire_pkg::phys_tag_t [SEARCHES-1:0] search_tags,
	input  retire_pkg::phys_tag_t [ENTRIES-1:0]  table_tags,
	output logic [ENTRIES-1:0][SEARCHES-1:0]     hits
);

	// Every entry compared against every search port in parallel
	always_comb begin
		for (int i = 0; i < ENTRIES; i++) begin
			for (int j = 0; j < SEARCHES; j++) begin
				hits[i][j] = enable[j] && (search_tags[j] == table_tags[i]);
			end
		end
	end

endmodule

// File: verification/retire_input.txt
# R followed by valid t_new t_old for each of ways 0 1 2 in decimal
# A followed by the tag the next pop must return
# M followed by an arch register and the tag it must map to
A 32
A 33
A 34
A 35
R 1 32 5 0 41 7 0 0 0
M 5 32
M 6 6
R 1 33 10 1 34 11 1 35 12
M 10 33
M 11 34
M 12 35
A 36
A 37
A 38
A 39
A 40
R 1 36 20 1 37 36 0 0 0
M 20 37
R 1 38 1 1 39 2 1 40 39
M 1 38
M 2 40
A 41
A 42
A 43
A 44
R 1 41 3 1 42 41 1 43 42
M 3 43
A 45
A 46
R 1 44 4 1 45 8 1 46 44
M 4 46
M 8 45
A 47
A 48
A 49
A 50
A 51
A 52
A 53
A 54
A 55
A 56
A 57
A 58
A 59
A 60
A 61
A 62
A 63
A 5
A 10
R 1 5 9 1 10 13 0 50 50
A 11
A 12
A 20
M 9 5
M 13 10
M 20 37

// File: verification/retire_unit_chk.sv
`timescale 1ns/10ps
`include "retire_config.svh"

module retire_unit_chk #(
	parameter bit WATCH_QUEUE = 1'b1,  // 1 on the free queue, 0 on the merge stage
	parameter int PTR_W = (retire_pkg::FREE_DEPTH > 1) ? $clog2(retire_pkg::FREE_DEPTH) : 1
) (
	input logic                                          clock,
	input logic                                          reset,
	input logic [$clog2(retire_pkg::FREE_DEPTH + 1)-1:0] count,
	input logic                                          take,
	input logic [PTR_W-1:0]                              head,
	input logic [`RETIRE_WIDTH-1:0]                      update_en,
	input retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0]     match_tag
);

	int failures = 0;  // Assertion failures so far

	generate
		if (WATCH_QUEUE) begin : queue_props
			count_bound: assert property (@(posedge clock) disable iff (reset)
				count <= retire_pkg::FREE_DEPTH)
			else begin
				$error("Free queue count %0d exceeds its depth", count);
				failures++;
			end

			// A take on an empty queue must not move the head
			no_empty_pop: assert property (@(posedge clock) disable iff (reset)
				(take && (count == '0)) |=> $stable(head))
			else begin
				$error("Take on an empty free queue moved the head");
				failures++;
			end
		end else begin : merge_props
			// Two surviving ways on one tag would write the same map entry twice
			for (genvar i = 0; i < `RETIRE_WIDTH; i++) begin : way_a
				for (genvar j = i + 1; j < `RETIRE_WIDTH; j++) begin : way_b
					single_match: assert property (@(posedge clock) disable iff (reset)
						!(update_en[i] && update_en[j] && (match_tag[i] == match_tag[j])))
					else begin
						$error("Ways %0d and %0d both update tag %0d", i, j, match_tag[i]);
						failures++;
					end
				end
			end
		end
	endgenerate

endmodule

// File: verification/retire_unit_tb.sv
`timescale 1ns/10ps
`include "retire_config.svh"

module retire_unit_tb;

	localparam string INPUT_FILE = "verification/retire_input.txt";
	localparam int    RESET_CYCLES = 10;

	logic                                      clock;
	logic                                      reset;
	logic [`RETIRE_WIDTH-1:0]                  retire_valid;
	retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0] retire_t_new;
	retire_pkg::phys_tag_t [`RETIRE_WIDTH-1:0] retire_t_old;
	logic                                      alloc_take;
	logic                                      alloc_valid;
	retire_pkg::phys_tag_t                     alloc_tag;
	retire_pkg::phys_tag_t [`NUM_ARCH_REG-1:0] arch_map;

	// Reference model state
	int ref_map [`NUM_ARCH_REG];
	int free_list [$];

	int limit_cycles = 0;  // Set once the stimulus file has been sized

	retire_unit dut_i (
		.clock        (clock),
		.reset        (reset),
		.retire_valid (retire_valid),
		.retire_t_new (retire_t_new),
		.retire_t_old (retire_t_old),
		.alloc_take   (alloc_take),
		.alloc_valid  (alloc_valid),
		.alloc_tag    (alloc_tag),
		.arch_map     (arch_map)
	);

	// Queue side watches count, takes and the head, merge side watches the surviving ways
	bind freed_reg_queue retire_unit_chk #(.WATCH_QUEUE(1'b1)) queue_chk_i (
		.clock     (clock),
		.reset     (reset),
		.count     (count),
		.take      (alloc_take),
		.head      (head),
		.update_en ('0),
		.match_tag ('0)
	);

	bind retire_merge retire_unit_chk #(.WATCH_QUEUE(1'b0)) merge_chk_i (
		.clock     (clock),
		.reset     (reset),
		.count     ('0),
		.take      (1'b0),
		.head      ('0),
		.update_en (out.update_en),
		.match_tag (out.match_tag)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped after a failure");
	endtask

	task automatic check_value(input int actual, input int expected, input string what);
		if (actual != expected) begin
			abort_run($sformatf("ERROR at %0d ns %s got %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	// Ways in order, each renames the arch register that holds its T_old
	function automatic void update_model(input int fields[9]);
		for (int w = 0; w < `RETIRE_WIDTH; w++) begin
			if (fields[3*w] != 0) begin
				for (int r = 0; r < `NUM_ARCH_REG; r++) begin
					if (ref_map[r] == fields[3*w+2]) begin
						ref_map[r] = fields[3*w+1];
					end
				end
				free_list.push_back(fields[3*w+2]);
			end
		end
	endfunction

	task automatic drive_idle();
		@(posedge clock);
		retire_valid <= '0;
		alloc_take   <= 1'b0;
	endtask

	task automatic drive_retire(input int fields[9]);
		@(posedge clock);
		alloc_take <= 1'b0;
		for (int w = 0; w < `RETIRE_WIDTH; w++) begin
			retire_valid[w] <= (fields[3*w] != 0);
			retire_t_new[w] <= retire_pkg::phys_tag_t'(fields[3*w+1]);
			retire_t_old[w] <= retire_pkg::phys_tag_t'(fields[3*w+2]);
		end
		update_model(fields);
	endtask

	// Hold take high until a tag is offered, then let it pop on the next edge
	task automatic take_free_tag(input int expected);
		@(posedge clock);
		retire_valid <= '0;
		alloc_take   <= 1'b1;
		@(negedge clock);
		while (!alloc_valid) begin
			@(posedge clock);
			@(negedge clock);
		end
		if (free_list.size() == 0) begin
			abort_run("A pop was requested but the reference free list is empty");
		end
		check_value(alloc_tag, expected, "alloc_tag");
		check_value(free_list[0], expected, "reference free list head");
		void'(free_list.pop_front());
		@(posedge clock);
		alloc_take <= 1'b0;
	endtask

	task automatic check_mapping(input int arch_reg, input int expected);
		drive_idle();
		drive_idle();  // Merge edge, then map write edge
		@(negedge clock);
		check_value(arch_map[arch_reg], expected, $sformatf("arch_map[%0d]", arch_reg));
		check_value(ref_map[arch_reg], expected, $sformatf("reference map[%0d]", arch_reg));
	endtask

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		abort_run($sformatf("Run timed out after %0d clock cycles", limit_cycles));
	end

	initial begin : assertion_monitor
		wait (dut_i.freed_reg_queue_i.queue_chk_i.failures
			+ dut_i.retire_merge_i.merge_chk_i.failures != 0);
		abort_run("A bound assertion on the queue or the merge stage failed");
	end

	initial begin : stimulus
		int    fd;
		int    line_count;
		int    n;
		int    arch_reg;
		int    tag;
		int    fields[9];
		string line;
		string op;

		void'($urandom(32'h2761));
		reset        = 1'b1;
		retire_valid = '0;
		retire_t_new = '0;
		retire_t_old = '0;
		alloc_take   = 1'b0;

		for (int r = 0; r < `NUM_ARCH_REG; r++) begin
			ref_map[r] = r;
		end
		for (int i = 0; i < retire_pkg::FREE_DEPTH; i++) begin
			free_list.push_back(`NUM_ARCH_REG + i);
		end

		if (`RETIRE_WIDTH != 3) begin
			abort_run("The stimulus file is written for three retire ways");
		end

		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			abort_run({"Could not open the stimulus file ", INPUT_FILE});
		end
		line_count = 0;
		while ($fgets(line, fd) != 0) begin
			line_count++;
		end
		$fclose(fd);
		// Ten cycles per line, the reset, and the final drain
		limit_cycles = line_count * 10 + RESET_CYCLES + 4 * retire_pkg::FREE_DEPTH;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		for (int r = 0; r < `NUM_ARCH_REG; r++) begin
			check_value(arch_map[r], r, $sformatf("arch_map[%0d] after reset", r));
		end
		check_value(alloc_valid, 1, "alloc_valid after reset");

		fd = $fopen(INPUT_FILE, "r");
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%s", op);
			if (n == 1 && op.getc(0) != "#") begin
				repeat ($urandom % 4) drive_idle();
				case (op)
					"R": begin
						n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d", op,
							fields[0], fields[1], fields[2], fields[3], fields[4],
							fields[5], fields[6], fields[7], fields[8]);
						if (n != 10) begin
							abort_run({"Malformed retire line in stimulus file: ", line});
						end
						drive_retire(fields);
					end
					"A": begin
						n = $sscanf(line, "%s %d", op, tag);
						if (n != 2) begin
							abort_run({"Malformed pop line in stimulus file: ", line});
						end
						take_free_tag(tag);
					end
					"M": begin
						n = $sscanf(line, "%s %d %d", op, arch_reg, tag);
						if (n != 3) begin
							abort_run({"Malformed map line in stimulus file: ", line});
						end
						check_mapping(arch_reg, tag);
					end
					default: abort_run({"Unknown operation in stimulus file: ", line});
				endcase
			end
		end
		$fclose(fd);

		// Every tag still owed by the model must come out in order
		while (free_list.size() != 0) begin
			take_free_tag(free_list[0]);
		end

		// A take on the empty queue is ignored
		@(posedge clock);
		alloc_take <= 1'b1;
		@(negedge clock);
		check_value(alloc_valid, 0, "alloc_valid after drain");
		drive_idle();
		@(negedge clock);
		check_value(alloc_valid, 0, "alloc_valid after a take on the empty queue");
		for (int r = 0; r < `NUM_ARCH_REG; r++) begin
			check_value(arch_map[r], ref_map[r], $sformatf("final arch_map[%0d]", r));
		end
		drive_idle();  // One more edge for the bound assertions
		@(negedge clock);

		if (dut_i.freed_reg_queue_i.queue_chk_i.failures
				+ dut_i.retire_merge_i.merge_chk_i.failures == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run("Assertion failures were reported during the run");
		end
	end

endmodule
